/* all.f */
+incdir+rtl
+incdir+testbench
rtl/heapStorePkg.sv
rtl/heapOpsPkg.sv
rtl/heapSequencer.sv
rtl/scanCounter.sv
rtl/arrayAllocator.sv
rtl/elementStore.sv
rtl/elementAlu.sv
rtl/arrayHeap.sv
testbench/arrayHeapTb.sv

/* rtl/arrayAllocator.sv */
// Array allocator
// Allocation bits, high-water count and LIFO free list

`timescale 1ns/1ps
`include "heap_macros.svh"

module arrayAllocator import heapStorePkg::*; (
  input  logic   clock,
  input  logic   resetN,
  input  logic   allocate,                              // Grant grantedId
  input  logic   releaseArray,                          // Free queryId
  input  arrayId queryId,
  output logic   allocated,
  output logic   neverAllocated,
  output arrayId grantedId,
  output logic   outOfMemory
);

  logic [`HEAP_ARRAYS-1:0]      allocBits;              // Live arrays
  logic [`HEAP_ADDRESS_BITS:0]  highWater;              // Arrays ever handed out
  logic [`HEAP_ADDRESS_BITS:0]  freeTop;                // Free list depth
  arrayId                       freeStack [`HEAP_ARRAYS];
  arrayId                       topIndex;

  assign topIndex       = arrayId'(freeTop) - 1'b1;     // Most recently freed
  assign grantedId      = (freeTop != '0) ? freeStack[topIndex] : arrayId'(highWater);
  assign allocated      = allocBits[queryId];
  assign neverAllocated = {1'b0, queryId} >= highWater;
  assign outOfMemory    = (freeTop == '0) && (highWater == `HEAP_ARRAYS);

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      allocBits <= '0;
      highWater <= '0;
      freeTop   <= '0;
    end
    else if (allocate) begin
      allocBits[grantedId] <= 1'b1;
      if (freeTop != '0) freeTop <= freeTop - 1'b1;     // Reuse before growing
      else highWater <= highWater + 1'b1;
    end
    else if (releaseArray) begin
      allocBits[queryId] <= 1'b0;
      freeTop            <= freeTop + 1'b1;
    end
  end

  // Free list entries
  always_ff @(posedge clock) begin
    if (releaseArray && !allocate) freeStack[arrayId'(freeTop)] <= queryId;
  end

  // Each id is freed at most once per allocation
  assert property (@(posedge clock) disable iff (!resetN) freeTop <= `HEAP_ARRAYS);

endmodule

/* rtl/arrayHeap.sv */
// Array heap top level
// Sequencer, allocator, store, scan counter and element ALU

`timescale 1ns/1ps

module arrayHeap import heapOpsPkg::*, heapStorePkg::*; (
  input  logic       clock,
  input  logic       resetN,
  input  logic       start,
  input  heapCommand command,
  output logic       busy,
  output logic       done,
  output heapResult  result
);

  logic        allocated, neverAllocated, outOfMemory;
  logic        allocate, releaseArray, setSize;
  logic        scanClear, scanStep, scanDone;
  arrayId      grantedId;
  arraySize    size, newSize, scanResult;
  elementWord  element, scanElement, newValue, reportValue;
  elementIndex scanPosition;
  storeWrite   write;                                   // Store address and write
  heapCommand  activeCommand;

  heapSequencer heapSequencer_i (
    .clock, .resetN, .start, .command,
    .allocated, .neverAllocated, .outOfMemory, .grantedId,
    .size, .element, .scanDone, .scanResult, .newValue, .reportValue,
    .allocate, .releaseArray, .write, .setSize, .newSize,
    .scanClear, .scanStep, .activeCommand, .busy, .done, .result
  );

  arrayAllocator arrayAllocator_i (
    .clock, .resetN, .allocate, .releaseArray,
    .queryId (activeCommand.arrayId),
    .allocated, .neverAllocated, .grantedId, .outOfMemory
  );

  elementStore elementStore_i (
    .clock, .resetN, .write, .setSize,
    .sizeId    (write.arrayId),                         // Granted id on Alloc
    .newSize,
    .readId    (write.arrayId),
    .readIndex (write.index),
    .scanIndex (scanPosition),
    .element, .scanElement, .size
  );

  scanCounter scanCounter_i (
    .clock, .resetN,
    .clear     (scanClear),
    .step      (scanStep),
    .size,
    .element   (scanElement),
    .target    (activeCommand.data),
    .position  (scanPosition),
    .finished  (scanDone),
    .lastMatch (scanResult)
  );

  elementAlu elementAlu_i (
    .op   (activeCommand.op),
    .element,
    .data (activeCommand.data),
    .newValue, .reportValue
  );

endmodule

/* rtl/elementAlu.sv */
// Element update ALU
// New element value and reported value per opcode

`timescale 1ns/1ps

module elementAlu import heapOpsPkg::*, heapStorePkg::*; (
  input  heapOp      op,
  input  elementWord element,                           // Current element
  input  elementWord data,                              // Command operand
  output elementWord newValue,
  output elementWord reportValue
);

  always_comb begin
    newValue = element;                                 // Unchanged for other ops
    case (op)
      OpAdd, OpAddAfter:      newValue = element + data; // Wraps at word width
      OpSubtract, OpSubAfter: newValue = element - data;
      OpOr:                   newValue = element | data;
      OpXor:                  newValue = element ^ data;
      OpAnd:                  newValue = element & data;
      default: ;
    endcase
  end

  // After variants report the old element
  assign reportValue = (op == OpAddAfter || op == OpSubAfter) ? element : newValue;

endmodule

/* rtl/elementStore.sv */
// Element memory and per-array size table
// Combinational reads for the command and the scan

`timescale 1ns/1ps
`include "heap_macros.svh"

module elementStore import heapStorePkg::*; (
  input  logic        clock,
  input  logic        resetN,
  input  storeWrite   write,
  input  logic        setSize,
  input  arrayId      sizeId,                           // Array whose size changes
  input  arraySize    newSize,
  input  arrayId      readId,
  input  elementIndex readIndex,
  input  elementIndex scanIndex,
  output elementWord  element,
  output elementWord  scanElement,
  output arraySize    size                              // Size of readId
);

  elementWord memory [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];
  arraySize   sizes  [`HEAP_ARRAYS];

  assign element     = memory[readId][readIndex];
  assign scanElement = memory[readId][scanIndex];
  assign size        = sizes[readId];

  // --------------------------------------------------
  // Element memory
  always_ff @(posedge clock) begin
    if (write.enable) memory[write.arrayId][write.index] <= write.word;
  end

  // Size table, empty after reset
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) sizes[i] <= '0;
    end
    else if (setSize) begin
      sizes[sizeId] <= newSize;
    end
  end

  // Sequencer never grows an array past its length
  assert property (@(posedge clock) disable iff (!resetN)
    setSize |-> newSize <= `HEAP_ARRAY_LENGTH);

endmodule

/* rtl/heapOpsPkg.sv */
// Command side of the array heap
// Opcode and error enums, command and result structs

`include "heap_macros.svh"

package heapOpsPkg;
  import heapStorePkg::*;

  typedef enum logic [4:0] {
    OpWrite    = 5'd2,                                  // Write an element
    OpRead     = 5'd3,                                  // Read an element
    OpSize     = 5'd4,                                  // Current size of an array
    OpIndex    = 5'd7,                                  // Last match position plus one
    OpPush     = 5'd14,                                 // Append if not full
    OpPop      = 5'd15,                                 // Remove last if not empty
    OpAlloc    = 5'd18,                                 // Take a new or freed array
    OpFree     = 5'd19,                                 // Return an array for reuse
    OpAdd      = 5'd20,                                 // Add, report new value
    OpAddAfter = 5'd21,                                 // Add, report old value
    OpSubtract = 5'd22,                                 // Subtract, report new value
    OpSubAfter = 5'd23,                                 // Subtract, report old value
    OpOr       = 5'd28,
    OpXor      = 5'd29,
    OpAnd      = 5'd30
  } heapOp;

  typedef enum logic [2:0] {
    ErrNone,
    ErrNeverAllocated,                                  // Beyond the high-water mark
    ErrFreed,                                           // Allocated once, now free
    ErrOutOfBounds,                                     // Index at or past the size
    ErrFull,
    ErrEmpty,
    ErrOutOfMemory                                      // No array left to grant
  } heapError;

  typedef struct packed {
    heapOp                         op;
    logic [`HEAP_ADDRESS_BITS-1:0] arrayId;
    elementIndex                   index;
    elementWord                    data;
  } heapCommand;                                        // 27 bits

  typedef struct packed {
    elementWord data;
    heapError   error;
  } heapResult;                                         // 19 bits
endpackage

/* rtl/heapSequencer.sv */
// Command FSM of the array heap
// Captures a command, checks it, then steps the operation
// Drives the allocator, the store and the scan counter

`timescale 1ns/1ps
`include "heap_macros.svh"

module heapSequencer import heapOpsPkg::*, heapStorePkg::*; (
  input  logic       clock,
  input  logic       resetN,
  input  logic       start,
  input  heapCommand command,
  input  logic       allocated,                         // Addressed array is live
  input  logic       neverAllocated,
  input  logic       outOfMemory,
  input  arrayId     grantedId,                         // Next id Alloc would get
  input  arraySize   size,
  input  elementWord element,
  input  logic       scanDone,
  input  arraySize   scanResult,
  input  elementWord newValue,                          // From the element ALU
  input  elementWord reportValue,
  output logic       allocate,
  output logic       releaseArray,
  output storeWrite  write,                             // Store address and write
  output logic       setSize,
  output arraySize   newSize,
  output logic       scanClear,
  output logic       scanStep,
  output heapCommand activeCommand,                     // Captured command for the ALU
  output logic       busy,
  output logic       done,
  output heapResult  result
);

  typedef enum logic [2:0] {Idle, Check, Execute, Scan, Finish} seqState;

  seqState    state;
  heapCommand cmd;                                      // Command under way
  heapError   errorCode;                                // Registered in Check
  heapError   checkError;
  elementWord reportData;                               // Registered in Execute
  elementWord reportNext;
  logic       updateOp;
  logic       boundsOp;
  logic       noError;

  assign updateOp      = cmd.op inside {OpAdd, OpAddAfter, OpSubtract, OpSubAfter,
                                        OpOr, OpXor, OpAnd};
  assign boundsOp      = updateOp || (cmd.op == OpRead);
  assign noError       = errorCode == ErrNone;
  assign activeCommand = cmd;
  assign busy          = state != Idle;
  assign scanStep      = (state == Scan) && !scanDone;

  // --------------------------------------------------
  // Error priority as checked in the Check cycle
  always_comb begin
    checkError = ErrNone;
    if (cmd.op == OpAlloc) begin
      if (outOfMemory) checkError = ErrOutOfMemory;
    end
    else if (neverAllocated) checkError = ErrNeverAllocated;
    else if (!allocated) checkError = ErrFreed;
    else if (boundsOp && {1'b0, cmd.index} >= size) checkError = ErrOutOfBounds;
    else if (cmd.op == OpPush && size == arraySize'(`HEAP_ARRAY_LENGTH)) checkError = ErrFull;
    else if (cmd.op == OpPop && size == '0) checkError = ErrEmpty;
  end

  // --------------------------------------------------
  // One strobe per operation in the Execute cycle
  always_comb begin
    write.enable  = 1'b0;
    write.arrayId = (cmd.op == OpAlloc) ? grantedId : cmd.arrayId;
    write.index   = cmd.index;
    write.word    = updateOp ? newValue : cmd.data;
    if (cmd.op == OpPush) write.index = elementIndex'(size);          // Slot after the last
    if (cmd.op == OpPop)  write.index = elementIndex'(size - 1'b1);   // Last element
    allocate     = 1'b0;
    releaseArray = 1'b0;
    setSize      = 1'b0;
    newSize      = size;
    scanClear    = 1'b0;
    reportNext   = '0;
    if (state == Execute && noError) begin
      case (cmd.op)
        OpWrite: begin
          write.enable = 1'b1;
          reportNext   = cmd.data;
          if ({1'b0, cmd.index} >= size) begin                        // Grow to cover index
            setSize = 1'b1;
            newSize = {1'b0, cmd.index} + 1'b1;
          end
        end
        OpRead: reportNext = element;
        OpSize: reportNext = elementWord'(size);
        OpPush: begin
          write.enable = 1'b1;
          setSize      = 1'b1;
          newSize      = size + 1'b1;
          reportNext   = cmd.data;
        end
        OpPop: begin
          setSize    = 1'b1;
          newSize    = size - 1'b1;
          reportNext = element;                                       // Element below old size
        end
        OpAlloc: begin
          allocate   = 1'b1;
          setSize    = 1'b1;                                          // New array starts empty
          newSize    = '0;
          reportNext = elementWord'(grantedId);
        end
        OpFree:  releaseArray = 1'b1;
        OpIndex: scanClear    = 1'b1;
        OpAdd, OpAddAfter, OpSubtract, OpSubAfter, OpOr, OpXor, OpAnd: begin
          write.enable = 1'b1;
          reportNext   = reportValue;
        end
        default: ;
      endcase
    end
  end

  // --------------------------------------------------
  // Control state
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      state     <= Idle;
      done      <= 1'b0;
      errorCode <= ErrNone;
    end
    else begin
      done <= 1'b0;
      case (state)
        Idle:    if (start) state <= Check;
        Check: begin
          errorCode <= checkError;
          state     <= Execute;
        end
        Execute: state <= (noError && cmd.op == OpIndex) ? Scan : Finish;
        Scan: begin
          if (scanDone) begin                                         // Done straight from scan
            state <= Finish;
            done  <= 1'b1;
          end
        end
        Finish: begin
          if (done) state <= Idle;                                    // Leave once done was seen
          else done <= 1'b1;
        end
        default: state <= Idle;
      endcase
    end
  end

  // Payload, loaded on the edge that raises done
  always_ff @(posedge clock) begin
    if (state == Idle && start) cmd <= command;
    if (state == Execute) reportData <= reportNext;
    if (state == Scan && scanDone) result <= '{data: elementWord'(scanResult), error: ErrNone};
    if (state == Finish && !done) result <= '{data: reportData, error: errorCode};
  end

  // Done is a single pulse and is never seen in Idle
  assert property (@(posedge clock) disable iff (!resetN) done |=> !done);
  assert property (@(posedge clock) disable iff (!resetN) done |-> state != Idle);

endmodule

/* rtl/heapStorePkg.sv */
// Storage side of the array heap
// Array, index, word and size types, store write bus

`include "heap_macros.svh"

package heapStorePkg;
  typedef logic [`HEAP_ADDRESS_BITS-1:0] arrayId;
  typedef logic [`HEAP_INDEX_BITS-1:0]   elementIndex;
  typedef logic [`HEAP_DATA_BITS-1:0]    elementWord;
  typedef logic [`HEAP_INDEX_BITS:0]     arraySize;     // Holds 0 up to the full length

  // Address is presented at all times, enable marks a real write
  typedef struct packed {
    logic                          enable;
    logic [`HEAP_ADDRESS_BITS-1:0] arrayId;
    elementIndex                   index;
    elementWord                    word;
  } storeWrite;                                         // 23 bits
endpackage

/* rtl/heap_macros.svh */
// Array heap widths and depths
// Array count and array length follow from the bit widths

`ifndef HEAP_MACROS_SVH
`define HEAP_MACROS_SVH

`define HEAP_ADDRESS_BITS 3                             // Bits in an array number
`define HEAP_INDEX_BITS   3                             // Bits in an element index
`define HEAP_DATA_BITS    16                            // Width of an element

`define HEAP_ARRAYS       (1 << `HEAP_ADDRESS_BITS)     // Number of arrays
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)       // Elements per array

`endif

/* rtl/scanCounter.sv */
// Position counter and match recorder for Index
// Walks an array one element per step

`timescale 1ns/1ps

module scanCounter import heapStorePkg::*; (
  input  logic        clock,
  input  logic        resetN,
  input  logic        clear,                            // Restart at position zero
  input  logic        step,
  input  arraySize    size,                             // Elements to walk
  input  elementWord  element,                          // Element at position
  input  elementWord  target,
  output elementIndex position,
  output logic        finished,
  output arraySize    lastMatch                         // Last match plus one, zero if none
);

  arraySize count;                                      // Elements already walked

  assign position = elementIndex'(count);
  assign finished = count >= size;                      // Empty array ends at once

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      count     <= '0;
      lastMatch <= '0;
    end
    else if (clear) begin
      count     <= '0;
      lastMatch <= '0;
    end
    else if (step && !finished) begin
      if (element == target) lastMatch <= count + 1'b1; // Later match overrides
      count <= count + 1'b1;
    end
  end

endmodule

/* testbench/heapTable.svh */
// Stimulus and expected-value rows for the array heap testbench
// Columns are op, array, index, data, expected data, expected error, check data

task automatic fillTable();
  // --------------------------------------------------
  // Allocation, free and reuse
  addRow(OpWrite,    0, 0, 16'h1234, 16'h0000, ErrNeverAllocated, 0); // Nothing allocated yet
  addRow(OpAlloc,    0, 0, 16'h0000, 16'h0000, ErrNone,           1);
  addRow(OpAlloc,    0, 0, 16'h0000, 16'h0001, ErrNone,           1);
  addRow(OpAlloc,    0, 0, 16'h0000, 16'h0002, ErrNone,           1);
  addRow(OpWrite,    1, 2, 16'h5555, 16'h5555, ErrNone,           1); // Size becomes 3
  addRow(OpFree,     1, 0, 16'h0000, 16'h0000, ErrNone,           0);
  addRow(OpRead,     1, 0, 16'h0000, 16'h0000, ErrFreed,          0);
  addRow(OpFree,     1, 0, 16'h0000, 16'h0000, ErrFreed,          0); // Second free
  addRow(OpAlloc,    0, 0, 16'h0000, 16'h0001, ErrNone,           1); // Freed id comes back
  addRow(OpSize,     1, 0, 16'h0000, 16'h0000, ErrNone,           1); // Reused array is empty
  // Write growth and Read on array 0
  addRow(OpWrite,    0, 0, 16'h1111, 16'h1111, ErrNone,           1);
  addRow(OpWrite,    0, 3, 16'h3333, 16'h3333, ErrNone,           1); // Size becomes 4
  addRow(OpSize,     0, 0, 16'h0000, 16'h0004, ErrNone,           1);
  addRow(OpWrite,    0, 1, 16'h2222, 16'h2222, ErrNone,           1);
  addRow(OpWrite,    0, 2, 16'h1111, 16'h1111, ErrNone,           1);
  addRow(OpRead,     0, 3, 16'h0000, 16'h3333, ErrNone,           1);
  addRow(OpRead,     0, 4, 16'h0000, 16'h0000, ErrOutOfBounds,    0); // Index at size
  // --------------------------------------------------
  // Index scans
  addRow(OpIndex,    0, 0, 16'h1111, 16'h0003, ErrNone,           1); // Last of two matches
  addRow(OpIndex,    0, 0, 16'h3333, 16'h0004, ErrNone,           1);
  addRow(OpIndex,    0, 0, 16'h9999, 16'h0000, ErrNone,           1); // No match
  addRow(OpIndex,    2, 0, 16'h0000, 16'h0000, ErrNone,           1); // Empty array
  addRow(OpIndex,    6, 0, 16'h0000, 16'h0000, ErrNeverAllocated, 0);
  // Push and Pop
  addRow(OpPop,      2, 0, 16'h0000, 16'h0000, ErrEmpty,          0);
  addRow(OpPush,     0, 0, 16'h0A05, 16'h0A05, ErrNone,           1);
  addRow(OpPush,     0, 0, 16'h0A06, 16'h0A06, ErrNone,           1);
  addRow(OpPush,     0, 0, 16'h0A07, 16'h0A07, ErrNone,           1);
  addRow(OpPush,     0, 0, 16'h0A08, 16'h0A08, ErrNone,           1); // Array now full
  addRow(OpPush,     0, 0, 16'h0A09, 16'h0000, ErrFull,           0);
  addRow(OpPop,      0, 0, 16'h0000, 16'h0A08, ErrNone,           1);
  addRow(OpPop,      0, 0, 16'h0000, 16'h0A07, ErrNone,           1);
  // --------------------------------------------------
  // Element updates on array 1
  addRow(OpWrite,    1, 0, 16'h00F0, 16'h00F0, ErrNone,           1);
  addRow(OpWrite,    1, 1, 16'hFFFE, 16'hFFFE, ErrNone,           1);
  addRow(OpAdd,      1, 0, 16'h0010, 16'h0100, ErrNone,           1); // New sum
  addRow(OpAddAfter, 1, 0, 16'h0005, 16'h0100, ErrNone,           1); // Old value
  addRow(OpRead,     1, 0, 16'h0000, 16'h0105, ErrNone,           1);
  addRow(OpAddAfter, 1, 1, 16'h0003, 16'hFFFE, ErrNone,           1); // Stores 0001 by wrap
  addRow(OpSubtract, 1, 0, 16'h0006, 16'h00FF, ErrNone,           1);
  addRow(OpSubAfter, 1, 1, 16'h0002, 16'h0001, ErrNone,           1);
  addRow(OpRead,     1, 1, 16'h0000, 16'hFFFF, ErrNone,           1); // Wrapped below zero
  addRow(OpOr,       1, 0, 16'h0F00, 16'h0FFF, ErrNone,           1);
  addRow(OpXor,      1, 0, 16'h00F0, 16'h0F0F, ErrNone,           1);
  addRow(OpAnd,      1, 0, 16'h3C3C, 16'h0C0C, ErrNone,           1);
  // Exhaustion and LIFO reuse
  addRow(OpAlloc,    0, 0, 16'h0000, 16'h0003, ErrNone,           1);
  addRow(OpAlloc,    0, 0, 16'h0000, 16'h0004, ErrNone,           1);
  addRow(OpAlloc,    0, 0, 16'h0000, 16'h0005, ErrNone,           1);
  addRow(OpAlloc,    0, 0, 16'h0000, 16'h0006, ErrNone,           1);
  addRow(OpAlloc,    0, 0, 16'h0000, 16'h0007, ErrNone,           1); // All 8 in use
  addRow(OpAlloc,    0, 0, 16'h0000, 16'h0000, ErrOutOfMemory,    0);
  addRow(OpFree,     5, 0, 16'h0000, 16'h0000, ErrNone,           0);
  addRow(OpFree,     6, 0, 16'h0000, 16'h0000, ErrNone,           0);
  addRow(OpAlloc,    0, 0, 16'h0000, 16'h0006, ErrNone,           1); // Last freed first
  addRow(OpAlloc,    0, 0, 16'h0000, 16'h0005, ErrNone,           1);
endtask

/* testbench/arrayHeapTb.sv */
// Array heap testbench
// Clock, reset, table-driven commands, done waits and result checks

`timescale 1ns/1ps

module arrayHeapTb import heapOpsPkg::*, heapStorePkg::*; ();

  typedef struct packed {
    heapCommand command;
    elementWord expData;
    heapError   expError;
    logic       checkData;                              // Error rows skip the data compare
  } tableRow;

  logic       clock;
  logic       resetN;
  logic       start;
  heapCommand command;
  logic       busy;
  logic       done;
  heapResult  result;
  tableRow    rows[$];

  arrayHeap arrayHeap_i (.clock, .resetN, .start, .command, .busy, .done, .result);

  task automatic addRow(input heapOp op, input int arrayNum, input int index,
                        input elementWord data, input elementWord expData,
                        input heapError expError, input bit checkData);
    tableRow row;
    row.command.op      = op;
    row.command.arrayId = arrayId'(arrayNum);
    row.command.index   = elementIndex'(index);
    row.command.data    = data;
    row.expData         = expData;
    row.expError        = expError;
    row.checkData       = checkData;
    rows.push_back(row);
  endtask

  `include "heapTable.svh"

  task automatic failRun(input string message);
    $display("%s", message);
    $display("STATUS: FAIL");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  // --------------------------------------------------
  // One command, from start pulse to idle again
  task automatic runRow(input int r);
    int      cycles;
    tableRow row;
    row = rows[r];
    @(posedge clock);
    command <= row.command;
    start   <= 1'b1;
    @(posedge clock);                                   // Start sampled on this edge
    start   <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clock);
      cycles++;
      @(negedge clock);                                 // Outputs settled mid-cycle
      assert (busy)
        else failRun($sformatf("** Error at time %0t: row %0d busy low before done",
                               $time, r));
    end while (!done && cycles < 40);
    if (!done) failRun($sformatf("Row %0d never finished within 40 cycles", r));
    if (row.command.op != OpIndex) begin
      assert (cycles == 3)
        else failRun($sformatf("** Error at time %0t: row %0d done after %0d cycles, expected 3",
                               $time, r, cycles));
    end
    assert (result.error == row.expError)
      else failRun($sformatf("** Error at time %0t: row %0d error %s, expected %s",
                             $time, r, result.error.name(), row.expError.name()));
    if (row.checkData) begin
      assert (result.data == row.expData)
        else failRun($sformatf("** Error at time %0t: row %0d data %h, expected %h",
                               $time, r, result.data, row.expData));
    end
    @(negedge clock);                                   // Done is a single pulse
    assert (!done)
      else failRun($sformatf("** Error at time %0t: row %0d done held past one cycle",
                             $time, r));
    cycles = 0;
    while (busy && cycles < 40) begin
      @(negedge clock);
      cycles++;
    end
    if (busy) failRun($sformatf("Row %0d left the DUT busy after done", r));
  endtask

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;                         // 20 ns period
  end

  initial begin
    resetN  = 1'b0;
    start   = 1'b0;
    command = '0;
    fillTable();
    repeat (4) @(posedge clock);
    resetN <= 1'b1;
    @(negedge clock);
    assert (!busy && !done) else failRun("DUT was not idle after reset");
    foreach (rows[r]) runRow(r);
    $display("STATUS: PASS");
    $finish;
  end

endmodule
